/* build.f */
pktPkg.sv
nodePkg.sv
rewardFsm.sv
clusterTimer.sv
packetSelect.sv
packetBuild.sv
reward.sv
tbClock.sv
rewardTb.sv

/* clusterTimer.sv */
module clusterTimer (
    input  logic            clk,
    input  logic            nrst,
    input  logic            en,
    input  logic            idle,
    input  logic            decide,
    input  pktPkg::pktTypeT rxType,
    input  nodePkg::txKindT txKind,
    output logic            expired,
    output logic            hbLock
);

    logic [nodePkg::TIMER_W-1:0] count;
    logic                        countDown;
    logic                        reload;

    // runs only between decisions, after the first heartbeat
    assign countDown = idle && !en && hbLock && (count != '0);
    // a timeout packet restarts the wait
    assign reload = decide &&
        ((txKind == nodePkg::MEMBER_REQ) || (txKind == nodePkg::CH_TIMESLOT));

    assign expired = (count == '0);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= nodePkg::TIMEOUT_INIT;
        end else if (reload) begin
            count <= nodePkg::TIMEOUT_INIT;
        end else if (countDown) begin
            count <= count - 1'b1;
        end
    end

    // lock blocks duplicate heartbeat ripples
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hbLock <= 1'b0;
        end else if (decide) begin
            case (rxType)
                pktPkg::HB: begin
                    hbLock <= 1'b1;
                end
                // data traffic means the round moved on
                pktPkg::DATA: begin
                    hbLock <= 1'b0;
                end
                default: begin
                    hbLock <= hbLock;
                end
            endcase
        end
    end

    // count stays within its reload range
    countInRange: assert property (@(posedge clk) disable iff (!nrst)
        count <= nodePkg::TIMEOUT_INIT);

endmodule

/* nodePkg.sv */
package nodePkg;

    // countdown width, enough for the reload value
    localparam int TIMER_W = 4;
    // reload and reset value of the cluster-phase timer
    localparam logic [TIMER_W-1:0] TIMEOUT_INIT = 4'd10;
    // invitations stop rippling at this distance from the CH
    localparam logic [pktPkg::WORD_W-1:0] MAX_CH_HOPS = 16'd4;

    // own node state as kept by the node info block
    typedef struct packed {
        logic [pktPkg::WORD_W-1:0] myNodeId;
        logic [pktPkg::WORD_W-1:0] hopsFromSink;
        logic [pktPkg::WORD_W-1:0] myQValue;
        logic [pktPkg::WORD_W-1:0] myEnergy;
        // 1 when this node is a cluster head
        logic                      role;
        logic                      lowEnergy;
        logic [pktPkg::WORD_W-1:0] timeslot;
        logic [pktPkg::WORD_W-1:0] chosenCh;
        logic [pktPkg::WORD_W-1:0] hopsFromCh;
        logic [pktPkg::WORD_W-1:0] chosenHop;
    } nodeInfoT;

    // outcome of one decision, listed in priority order
    typedef enum logic [2:0] {
        HB_RIPPLE   = 3'd0,
        INV_RIPPLE  = 3'd1,
        MEMBER_REQ  = 3'd2,
        CH_TIMESLOT = 3'd3,
        CH_INVITE   = 3'd4,
        DATA_FWD    = 3'd5,
        DATA_OWN    = 3'd6,
        NO_TX       = 3'd7
    } txKindT;

endpackage

/* packetBuild.sv */
module packetBuild (
    input  logic              clk,
    input  logic              nrst,
    input  logic              decide,
    input  nodePkg::txKindT   txKind,
    input  pktPkg::rxPktT     rxPkt,
    input  nodePkg::nodeInfoT node,
    output pktPkg::txPktT     txPkt
);

    pktPkg::txPktT           nextPkt;
    logic                    nextSink;
    logic [pktPkg::WORD_W-1:0] dataDest;
    pktPkg::pktTypeT         dataType;

    // one hop from the sink sends straight to it
    assign nextSink = (node.hopsFromSink == 16'd1);
    assign dataDest = nextSink ? pktPkg::SINK_ID : node.chosenHop;
    assign dataType = node.lowEnergy ? pktPkg::SOS : pktPkg::DATA;

    always_comb begin
        // unnamed fields stay zero
        nextPkt          = '0;
        nextPkt.pktType  = pktPkg::NONE;
        nextPkt.timeslot = node.timeslot;
        case (txKind)
            nodePkg::HB_RIPPLE: begin
                nextPkt.pktType       = pktPkg::HB;
                nextPkt.sourceId      = rxPkt.sourceId;
                nextPkt.qValue        = rxPkt.qValue;
                // one more hop away from the sink
                nextPkt.sourceHops    = node.hopsFromSink + 1'b1;
                nextPkt.energyLeft    = node.myEnergy;
                nextPkt.hopsFromCh    = '1;
                nextPkt.destinationId = pktPkg::BROADCAST_ID;
            end
            nodePkg::INV_RIPPLE: begin
                // CH identity carried through unchanged
                nextPkt.pktType       = pktPkg::INV;
                nextPkt.sourceId      = rxPkt.sourceId;
                nextPkt.qValue        = rxPkt.qValue;
                nextPkt.energyLeft    = rxPkt.energyLeft;
                nextPkt.sourceHops    = node.hopsFromCh;
                nextPkt.hopsFromCh    = rxPkt.hopsFromCh + 1'b1;
                nextPkt.destinationId = pktPkg::BROADCAST_ID;
            end
            nodePkg::MEMBER_REQ: begin
                nextPkt.pktType       = pktPkg::MR;
                nextPkt.sourceId      = node.myNodeId;
                nextPkt.sourceHops    = node.hopsFromSink;
                nextPkt.qValue        = node.myQValue;
                nextPkt.energyLeft    = node.myEnergy;
                nextPkt.hopsFromCh    = node.hopsFromCh;
                // request goes to the chosen CH only
                nextPkt.chosenCh      = node.chosenCh;
                nextPkt.destinationId = node.chosenCh;
            end
            nodePkg::CH_TIMESLOT: begin
                nextPkt.pktType       = pktPkg::CHT;
                nextPkt.sourceId      = node.myNodeId;
                nextPkt.sourceHops    = node.hopsFromSink;
                nextPkt.qValue        = node.myQValue;
                nextPkt.energyLeft    = node.myEnergy;
                nextPkt.chosenCh      = node.myNodeId;
                nextPkt.destinationId = pktPkg::BROADCAST_ID;
            end
            nodePkg::CH_INVITE: begin
                // CH is zero hops from itself
                nextPkt.pktType       = pktPkg::INV;
                nextPkt.sourceId      = node.myNodeId;
                nextPkt.sourceHops    = node.hopsFromSink;
                nextPkt.qValue        = node.myQValue;
                nextPkt.energyLeft    = node.myEnergy;
                nextPkt.hopsFromCh    = '0;
                nextPkt.destinationId = pktPkg::BROADCAST_ID;
            end
            nodePkg::DATA_FWD: begin
                nextPkt.pktType       = dataType;
                nextPkt.sourceId      = rxPkt.sourceId;
                nextPkt.sourceHops    = rxPkt.sourceHops;
                nextPkt.qValue        = rxPkt.qValue;
                nextPkt.energyLeft    = rxPkt.energyLeft;
                nextPkt.hopsFromCh    = rxPkt.hopsFromCh;
                nextPkt.chosenCh      = rxPkt.chosenCh;
                nextPkt.destinationId = dataDest;
            end
            nodePkg::DATA_OWN: begin
                nextPkt.pktType       = dataType;
                nextPkt.sourceId      = node.myNodeId;
                nextPkt.sourceHops    = node.hopsFromSink;
                nextPkt.qValue        = node.myQValue;
                nextPkt.energyLeft    = node.myEnergy;
                nextPkt.hopsFromCh    = node.hopsFromCh;
                // no CH needed right next to the sink
                nextPkt.chosenCh      = nextSink ? '0 : node.chosenCh;
                nextPkt.destinationId = dataDest;
            end
            default: begin
                nextPkt.pktType = pktPkg::NONE;
            end
        endcase
    end

    // held through back-pressure, skipped when nothing is sent
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            txPkt               <= '0;
            txPkt.pktType       <= pktPkg::NONE;
            txPkt.sourceId      <= '1;
            txPkt.sourceHops    <= '1;
            txPkt.hopsFromCh    <= '1;
            txPkt.destinationId <= pktPkg::BROADCAST_ID;
        end else if (decide && (txKind != nodePkg::NO_TX)) begin
            txPkt <= nextPkt;
        end
    end

    // a sent packet always carries a real type
    typeLoaded: assert property (@(posedge clk) disable iff (!nrst)
        (decide && (txKind != nodePkg::NO_TX)) |=> (txPkt.pktType != pktPkg::NONE));

endmodule

/* packetSelect.sv */
module packetSelect (
    input  pktPkg::rxPktT     rxPkt,
    input  nodePkg::nodeInfoT node,
    input  logic              iHaveData,
    input  logic              iAmDestination,
    input  logic              expired,
    input  logic              hbLock,
    output nodePkg::txKindT   txKind
);

    logic rxHb;
    logic rxInv;
    logic rxData;
    logic invInRange;

    assign rxHb   = (rxPkt.pktType == pktPkg::HB);
    assign rxInv  = (rxPkt.pktType == pktPkg::INV);
    // data and SOS are forwarded the same way
    assign rxData = (rxPkt.pktType == pktPkg::DATA) || (rxPkt.pktType == pktPkg::SOS);

    // invitations die out four hops from the CH
    assign invInRange = (rxPkt.hopsFromCh < nodePkg::MAX_CH_HOPS);

    // first matching rule wins
    always_comb begin
        if (rxHb && !hbLock) begin
            txKind = nodePkg::HB_RIPPLE;
        end else if (rxInv && invInRange) begin
            txKind = nodePkg::INV_RIPPLE;
        end else if (expired && !node.role) begin
            // member gave up waiting for invitations
            txKind = nodePkg::MEMBER_REQ;
        end else if (expired && node.role) begin
            // CH gave up waiting for membership requests
            txKind = nodePkg::CH_TIMESLOT;
        end else if (node.role && hbLock) begin
            txKind = nodePkg::CH_INVITE;
        end else if (iAmDestination && rxData) begin
            txKind = nodePkg::DATA_FWD;
        end else if (iHaveData) begin
            txKind = nodePkg::DATA_OWN;
        end else begin
            txKind = nodePkg::NO_TX;
        end
    end

endmodule

/* pktPkg.sv */
package pktPkg;

    // every header field is one word wide
    localparam int WORD_W = 16;

    // broadcast goes to every neighbor
    localparam logic [WORD_W-1:0] BROADCAST_ID = 16'hFFFF;
    // the sink always sits at address 0
    localparam logic [WORD_W-1:0] SINK_ID = 16'd0;

    // packet type codes as they appear on air
    typedef enum logic [2:0] {
        HB   = 3'b000,
        CHE  = 3'b001,
        INV  = 3'b010,
        MR   = 3'b011,
        CHT  = 3'b100,
        DATA = 3'b101,
        SOS  = 3'b110,
        NONE = 3'b111
    } pktTypeT;

    // header of the packet that was just received
    typedef struct packed {
        pktTypeT           pktType;
        logic [WORD_W-1:0] sourceId;
        logic [WORD_W-1:0] sourceHops;
        logic [WORD_W-1:0] qValue;
        logic [WORD_W-1:0] energyLeft;
        logic [WORD_W-1:0] hopsFromCh;
        logic [WORD_W-1:0] chosenCh;
    } rxPktT;

    // outgoing header, adds destination and timeslot
    typedef struct packed {
        pktTypeT           pktType;
        logic [WORD_W-1:0] sourceId;
        logic [WORD_W-1:0] sourceHops;
        logic [WORD_W-1:0] qValue;
        logic [WORD_W-1:0] energyLeft;
        logic [WORD_W-1:0] hopsFromCh;
        logic [WORD_W-1:0] chosenCh;
        logic [WORD_W-1:0] destinationId;
        logic [WORD_W-1:0] timeslot;
    } txPktT;

endpackage

/* reward.sv */
module reward (
    input  logic             clk,
    input  logic             nrst,
    input  logic             en,
    input  logic             okToSend,
    input  logic             iHaveData,
    input  logic             iAmDestination,
    input  pktPkg::rxPktT    rxPkt,
    input  nodePkg::nodeInfoT node,
    output pktPkg::txPktT    txPkt,
    output logic             pktValid,
    output logic             rewardDone
);

    logic            idle;
    logic            decide;
    logic            expired;
    logic            hbLock;
    nodePkg::txKindT txKind;

    // sequencing and handshake
    rewardFsm i_rewardFsm (
        .clk        (clk),
        .nrst       (nrst),
        .en         (en),
        .okToSend   (okToSend),
        .txKind     (txKind),
        .idle       (idle),
        .decide     (decide),
        .pktValid   (pktValid),
        .rewardDone (rewardDone)
    );

    // heartbeat lock and phase timeout
    clusterTimer i_clusterTimer (
        .clk     (clk),
        .nrst    (nrst),
        .en      (en),
        .idle    (idle),
        .decide  (decide),
        .rxType  (rxPkt.pktType),
        .txKind  (txKind),
        .expired (expired),
        .hbLock  (hbLock)
    );

    // which packet to send, if any
    packetSelect i_packetSelect (
        .rxPkt          (rxPkt),
        .node           (node),
        .iHaveData      (iHaveData),
        .iAmDestination (iAmDestination),
        .expired        (expired),
        .hbLock         (hbLock),
        .txKind         (txKind)
    );

    // header fields, registered on decide
    packetBuild i_packetBuild (
        .clk    (clk),
        .nrst   (nrst),
        .decide (decide),
        .txKind (txKind),
        .rxPkt  (rxPkt),
        .node   (node),
        .txPkt  (txPkt)
    );

endmodule

/* rewardFsm.sv */
module rewardFsm (
    input  logic            clk,
    input  logic            nrst,
    input  logic            en,
    input  logic            okToSend,
    input  nodePkg::txKindT txKind,
    output logic            idle,
    output logic            decide,
    output logic            pktValid,
    output logic            rewardDone
);

    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        S_PROCESS = 2'd1,
        S_DONE    = 2'd2
    } stateT;

    stateT state;
    stateT stateNext;
    logic  sendIt;
    logic  handOff;

    // a real packet was picked this cycle
    assign sendIt  = decide && (txKind != nodePkg::NO_TX);
    // packet accepted by the MAC
    assign handOff = (state == S_DONE) && okToSend;

    assign idle   = (state == S_IDLE);
    // process lasts exactly one cycle, so this is a pulse
    assign decide = (state == S_PROCESS);

    always_comb begin
        stateNext = state;
        case (state)
            S_IDLE: begin
                if (en) begin
                    stateNext = S_PROCESS;
                end
            end
            S_PROCESS: begin
                // nothing to send goes straight back
                stateNext = sendIt ? S_DONE : S_IDLE;
            end
            S_DONE: begin
                // hold here until the MAC takes it
                if (okToSend) begin
                    stateNext = S_IDLE;
                end
            end
            default: begin
                stateNext = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= S_IDLE;
            pktValid   <= 1'b0;
            rewardDone <= 1'b0;
        end else begin
            state <= stateNext;
            // valid follows done entry and exit
            if (sendIt) begin
                pktValid <= 1'b1;
            end else if (handOff) begin
                pktValid <= 1'b0;
            end
            // one cycle after the hand-off
            rewardDone <= handOff;
        end
    end

    // done pulse never stretches
    doneIsPulse: assert property (@(posedge clk) disable iff (!nrst)
        rewardDone |=> !rewardDone);

    // valid only while waiting in done
    validInDone: assert property (@(posedge clk) disable iff (!nrst)
        pktValid |-> (state == S_DONE));

endmodule

/* rewardTb.sv */
module rewardTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              nrst;
    logic              en;
    logic              okToSend;
    logic              iHaveData;
    logic              iAmDestination;
    pktPkg::rxPktT     rxPkt;
    nodePkg::nodeInfoT node;
    pktPkg::txPktT     txPkt;
    logic              pktValid;
    logic              rewardDone;

    // reference copy of phase, heartbeat lock and timer
    logic [1:0]                  modelPhase;
    logic                        modelLock;
    logic [nodePkg::TIMER_W-1:0] modelCount;
    nodePkg::txKindT             kindNow;
    pktPkg::txPktT               pktNow;
    nodePkg::txKindT             expKind;
    pktPkg::txPktT               expPkt;
    logic                        validLast;
    int                          errors;
    int                          timeouts;

    tbClock i_tbClock (
        .clk  (clk),
        .nrst (nrst)
    );

    reward i_reward (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .okToSend       (okToSend),
        .iHaveData      (iHaveData),
        .iAmDestination (iAmDestination),
        .rxPkt          (rxPkt),
        .node           (node),
        .txPkt          (txPkt),
        .pktValid       (pktValid),
        .rewardDone     (rewardDone)
    );

    task automatic checkValue(input string name, input logic [$bits(pktPkg::txPktT)-1:0] expVal,
                              input logic [$bits(pktPkg::txPktT)-1:0] actVal);
        assert (expVal == actVal) else begin
            $display("FAIL %s expected %0h actual %0h", name, expVal, actVal);
            errors++;
        end
    endtask

    // expected kind and header from the packet rules
    function automatic pktPkg::txPktT expectPkt(
        input pktPkg::rxPktT rx, input nodePkg::nodeInfoT nd, input logic have,
        input logic dest, input logic lock, input logic timeUp,
        output nodePkg::txKindT kind);
        pktPkg::txPktT p;
        logic          toSink;
        logic          rxData;
        logic          invOk;
        toSink = (nd.hopsFromSink == 16'd1);
        rxData = (rx.pktType == pktPkg::DATA) || (rx.pktType == pktPkg::SOS);
        invOk  = (rx.pktType == pktPkg::INV) && (rx.hopsFromCh < nodePkg::MAX_CH_HOPS);
        // lowest priority first, later rules override
        kind = nodePkg::NO_TX;
        if (have) kind = nodePkg::DATA_OWN;
        if (dest && rxData) kind = nodePkg::DATA_FWD;
        if (nd.role && lock) kind = nodePkg::CH_INVITE;
        if (timeUp && nd.role) kind = nodePkg::CH_TIMESLOT;
        if (timeUp && !nd.role) kind = nodePkg::MEMBER_REQ;
        if (invOk) kind = nodePkg::INV_RIPPLE;
        if ((rx.pktType == pktPkg::HB) && !lock) kind = nodePkg::HB_RIPPLE;
        p          = '0;
        p.pktType  = pktPkg::NONE;
        p.timeslot = nd.timeslot;
        case (kind)
            nodePkg::HB_RIPPLE: begin
                p.pktType       = pktPkg::HB;
                p.sourceId      = rx.sourceId;
                p.qValue        = rx.qValue;
                p.sourceHops    = nd.hopsFromSink + 16'd1;
                p.energyLeft    = nd.myEnergy;
                p.hopsFromCh    = 16'hFFFF;
                p.destinationId = pktPkg::BROADCAST_ID;
            end
            nodePkg::INV_RIPPLE: begin
                p.pktType       = pktPkg::INV;
                p.sourceId      = rx.sourceId;
                p.qValue        = rx.qValue;
                p.energyLeft    = rx.energyLeft;
                p.sourceHops    = nd.hopsFromCh;
                p.hopsFromCh    = rx.hopsFromCh + 16'd1;
                p.destinationId = pktPkg::BROADCAST_ID;
            end
            nodePkg::MEMBER_REQ, nodePkg::CH_TIMESLOT, nodePkg::CH_INVITE: begin
                // own identity in all three
                p.sourceId      = nd.myNodeId;
                p.sourceHops    = nd.hopsFromSink;
                p.qValue        = nd.myQValue;
                p.energyLeft    = nd.myEnergy;
                p.destinationId = pktPkg::BROADCAST_ID;
                p.pktType       = pktPkg::INV;
                if (kind == nodePkg::MEMBER_REQ) begin
                    p.pktType       = pktPkg::MR;
                    p.hopsFromCh    = nd.hopsFromCh;
                    p.chosenCh      = nd.chosenCh;
                    p.destinationId = nd.chosenCh;
                end else if (kind == nodePkg::CH_TIMESLOT) begin
                    p.pktType  = pktPkg::CHT;
                    p.chosenCh = nd.myNodeId;
                end
            end
            nodePkg::DATA_FWD, nodePkg::DATA_OWN: begin
                p.pktType       = nd.lowEnergy ? pktPkg::SOS : pktPkg::DATA;
                p.destinationId = toSink ? pktPkg::SINK_ID : nd.chosenHop;
                if (kind == nodePkg::DATA_FWD) begin
                    p.sourceId   = rx.sourceId;
                    p.sourceHops = rx.sourceHops;
                    p.qValue     = rx.qValue;
                    p.energyLeft = rx.energyLeft;
                    p.hopsFromCh = rx.hopsFromCh;
                    p.chosenCh   = rx.chosenCh;
                end else begin
                    p.sourceId   = nd.myNodeId;
                    p.sourceHops = nd.hopsFromSink;
                    p.qValue     = nd.myQValue;
                    p.energyLeft = nd.myEnergy;
                    p.hopsFromCh = nd.hopsFromCh;
                    p.chosenCh   = toSink ? 16'd0 : nd.chosenCh;
                end
            end
            default: p.pktType = pktPkg::NONE;
        endcase
        return p;
    endfunction

    function automatic pktPkg::rxPktT randomRx(input pktPkg::pktTypeT rxType);
        pktPkg::rxPktT r;
        r.pktType    = rxType;
        r.sourceId   = 16'($urandom);
        r.sourceHops = 16'($urandom_range(7, 0));
        r.qValue     = 16'($urandom);
        r.energyLeft = 16'($urandom);
        r.hopsFromCh = 16'($urandom_range(7, 0));
        r.chosenCh   = 16'($urandom);
        return r;
    endfunction

    function automatic nodePkg::nodeInfoT randomNode(input logic isCh);
        nodePkg::nodeInfoT n;
        n.myNodeId     = 16'($urandom);
        // hop 1 exercises the sink rule
        n.hopsFromSink = 16'($urandom_range(3, 1));
        n.myQValue     = 16'($urandom);
        n.myEnergy     = 16'($urandom);
        n.role         = isCh;
        n.lowEnergy    = 1'($urandom);
        n.timeslot     = 16'($urandom);
        n.chosenCh     = 16'($urandom);
        n.hopsFromCh   = 16'($urandom_range(3, 0));
        n.chosenHop    = 16'($urandom);
        return n;
    endfunction

    // one decision, from en through the hand-off
    task automatic transact(input pktPkg::rxPktT rx, input nodePkg::nodeInfoT nd,
                            input logic have, input logic dest,
                            input nodePkg::txKindT wantKind);
        int            edges;
        pktPkg::txPktT held;
        @(posedge clk);
        rxPkt          <= rx;
        node           <= nd;
        iHaveData      <= have;
        iAmDestination <= dest;
        en             <= 1'b1;
        @(posedge clk);
        en <= 1'b0;
        // valid due on the second edge after en
        edges = 1;
        @(negedge clk);
        while (!pktValid && edges < 4) begin
            @(negedge clk);
            edges++;
        end
        checkValue("txKind", wantKind, expKind);
        if (wantKind == nodePkg::NO_TX) begin
            checkValue("pktValid", 0, pktValid);
            checkValue("rewardDone", 0, rewardDone);
            return;
        end
        if (!pktValid) begin
            $display("timed out waiting for pktValid to rise");
            timeouts++;
            return;
        end
        checkValue("pktValid latency", 2, edges);
        // MAC holds off, packet must not move
        held = txPkt;
        repeat ($urandom_range(20, 0)) begin
            @(negedge clk);
            checkValue("txPkt", held, txPkt);
            checkValue("pktValid", 1, pktValid);
        end
        @(posedge clk);
        okToSend <= 1'b1;
        @(posedge clk);
        okToSend <= 1'b0;
        edges = 1;
        @(negedge clk);
        while (!rewardDone && edges < 4) begin
            @(negedge clk);
            edges++;
        end
        if (!rewardDone) begin
            $display("timed out waiting for rewardDone to rise");
            timeouts++;
            return;
        end
        checkValue("rewardDone latency", 1, edges);
        checkValue("pktValid", 0, pktValid);
        @(negedge clk);
        checkValue("rewardDone", 0, rewardDone);
    endtask

    // model steps on the same edges as the DUT
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            modelPhase <= 2'd0;
            modelLock  <= 1'b0;
            modelCount <= nodePkg::TIMEOUT_INIT;
            expKind    <= nodePkg::NO_TX;
            expPkt     <= '0;
        end else begin
            case (modelPhase)
                2'd0: begin
                    if (en) begin
                        modelPhase <= 2'd1;
                    end else if (modelLock && (modelCount != '0)) begin
                        modelCount <= modelCount - 1'b1;
                    end
                end
                2'd1: begin
                    pktNow = expectPkt(rxPkt, node, iHaveData, iAmDestination, modelLock,
                                       modelCount == '0, kindNow);
                    expPkt  <= pktNow;
                    expKind <= kindNow;
                    if (rxPkt.pktType == pktPkg::HB) begin
                        modelLock <= 1'b1;
                    end else if (rxPkt.pktType == pktPkg::DATA) begin
                        modelLock <= 1'b0;
                    end
                    if ((kindNow == nodePkg::MEMBER_REQ) || (kindNow == nodePkg::CH_TIMESLOT)) begin
                        modelCount <= nodePkg::TIMEOUT_INIT;
                    end
                    modelPhase <= (kindNow == nodePkg::NO_TX) ? 2'd0 : 2'd2;
                end
                default: begin
                    if (okToSend) begin
                        modelPhase <= 2'd0;
                    end
                end
            endcase
        end
    end

    // compare on every rise of pktValid
    always @(negedge clk) begin
        if (nrst && pktValid && !validLast) begin
            checkValue("txPkt", expPkt, txPkt);
        end
        validLast <= pktValid;
    end

    initial begin
        pktPkg::rxPktT     rx;
        nodePkg::nodeInfoT nd;
        nodePkg::txKindT   want;
        logic              have;
        logic              dest;
        int                waitCycles;
        errors         = 0;
        timeouts       = 0;
        validLast      = 1'b0;
        en             = 1'b0;
        okToSend       = 1'b0;
        iHaveData      = 1'b0;
        iAmDestination = 1'b0;
        rxPkt          = '0;
        node           = '0;
        void'($urandom(32'he339));
        waitCycles = 0;
        while ((nrst !== 1'b1) && (waitCycles < 10)) begin
            @(posedge clk);
            waitCycles++;
        end
        if (nrst !== 1'b1) begin
            $display("reset was never released");
            timeouts++;
        end
        // first heartbeat ripples, repeat is blocked, data clears the lock
        nd = randomNode(1'b0);
        transact(randomRx(pktPkg::HB), nd, 1'b0, 1'b0, nodePkg::HB_RIPPLE);
        transact(randomRx(pktPkg::HB), nd, 1'b0, 1'b0, nodePkg::NO_TX);
        transact(randomRx(pktPkg::DATA), nd, 1'b0, 1'b1, nodePkg::DATA_FWD);
        transact(randomRx(pktPkg::HB), nd, 1'b0, 1'b0, nodePkg::HB_RIPPLE);
        transact(randomRx(pktPkg::DATA), nd, 1'b0, 1'b0, nodePkg::NO_TX);
        // invitation ripple limit
        repeat (10) begin
            rx = randomRx(pktPkg::INV);
            want = (rx.hopsFromCh < nodePkg::MAX_CH_HOPS) ? nodePkg::INV_RIPPLE : nodePkg::NO_TX;
            transact(rx, randomNode(1'b0), 1'b0, 1'b0, want);
        end
        // lock set, then let the timer run out for member and CH
        transact(randomRx(pktPkg::HB), nd, 1'b0, 1'b0, nodePkg::HB_RIPPLE);
        repeat (nodePkg::TIMEOUT_INIT + 2) @(posedge clk);
        transact(randomRx(pktPkg::NONE), nd, 1'b0, 1'b0, nodePkg::MEMBER_REQ);
        transact(randomRx(pktPkg::NONE), nd, 1'b0, 1'b0, nodePkg::NO_TX);
        repeat (nodePkg::TIMEOUT_INIT + 2) @(posedge clk);
        nd = randomNode(1'b1);
        transact(randomRx(pktPkg::NONE), nd, 1'b0, 1'b0, nodePkg::CH_TIMESLOT);
        transact(randomRx(pktPkg::NONE), nd, 1'b0, 1'b0, nodePkg::CH_INVITE);
        // forward and own data with the lock clear
        transact(randomRx(pktPkg::DATA), randomNode(1'b0), 1'b0, 1'b0, nodePkg::NO_TX);
        repeat (24) begin
            rx = randomRx(($urandom_range(1, 0) != 0) ? pktPkg::SOS : pktPkg::DATA);
            have = 1'($urandom);
            dest = 1'($urandom);
            want = dest ? nodePkg::DATA_FWD : (have ? nodePkg::DATA_OWN : nodePkg::NO_TX);
            transact(rx, randomNode(1'($urandom)), have, dest, want);
        end
        $display("run over, errors %0d, timeouts %0d", errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rewardTb -f build.f -o rewardSim \
    && ./obj_dir/rewardSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failures"; exit 1; } || exit 0

/* tbClock.sv */
module tbClock (
    output logic clk,
    output logic nrst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for three rising edges
    initial begin
        nrst = 1'b0;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;
    end

endmodule
